// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exec_cluster_tb
FILELIST  := exec_cluster.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== exec_cluster.f ====
hw/rv_isa_pkg.sv
hw/ooo_pkg.sv
hw/alu.sv
hw/branch_cond.sv
hw/operand_select.sv
hw/alu_fu.sv
hw/cdb_arbiter.sv
hw/exec_cluster.sv
tb/exec_cluster_tb.sv

// ==== hw/alu.sv ====
// integer alu computing the ten rv32i register and immediate operations
`timescale 1ns/1ps
`default_nettype none

module alu
    import rv_isa_pkg::*;
(
    input  logic [xlen-1:0] opa,
    input  logic [xlen-1:0] opb,
    input  alu_func_e       func,
    output logic [xlen-1:0] result
);

    // signed views for slt and sra
    logic signed [xlen-1:0] signed_opa;
    logic signed [xlen-1:0] signed_opb;
    // shift amount is the low five bits only
    logic [4:0]             shamt;

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign shamt      = opb[4:0];

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            alu_slt:  result = {{(xlen-1){1'b0}}, signed_opa < signed_opb};
            alu_sltu: result = {{(xlen-1){1'b0}}, opa < opb};
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            alu_srl:  result = opa >> shamt;
            alu_sll:  result = opa << shamt;
            // sign bit fills from the left
            alu_sra:  result = signed_opa >>> shamt;
            // unused codes give a fixed word
            default:  result = poison_alu;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu_fu.sv ====
// alu functional unit with branch resolution and a result register held until cdb ack
`timescale 1ns/1ps
`default_nettype none

module alu_fu
    import rv_isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  logic [rob_tag_bits-1:0] rob_tag,
    input  alu_func_e               alu_func,
    input  opa_select_e             opa_select,
    input  opb_select_e             opb_select,
    input  logic [31:0]             inst,
    input  logic [xlen-1:0]         pc,
    input  logic [xlen-1:0]         npc,
    input  logic [xlen-1:0]         rs1_value,
    input  logic [xlen-1:0]         rs2_value,
    input  logic                    cond_branch,
    input  logic                    uncond_branch,
    input  logic                    ack,
    output logic                    ready,
    output logic                    done,
    output logic [rob_tag_bits-1:0] tag,
    output logic [xlen-1:0]         value,
    output logic                    take_branch,
    output logic [xlen-1:0]         branch_target
);

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] alu_result;
    logic            cond_take;
    logic            take_next;
    logic            accept;

    operand_select i_operand_select (
        .opa_select (opa_select),
        .opb_select (opb_select),
        .inst       (inst),
        .pc         (pc),
        .npc        (npc),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .opa        (opa),
        .opb        (opb)
    );

    alu i_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (alu_func),
        .result (alu_result)
    );

    // condition comes from funct3 of the instruction
    branch_cond i_branch_cond (
        .func (branch_funct3_e'(inst[14:12])),
        .rs1  (rs1_value),
        .rs2  (rs2_value),
        .take (cond_take)
    );

    assign take_next = uncond_branch | (cond_branch & cond_take);

    // register free now, or freed by this cycle's ack
    assign ready  = ~done | ack;
    assign accept = issue_valid & ready;

    // control flags
    always_ff @(posedge clock) begin
        if (reset) begin
            done        <= 1'b0;
            take_branch <= 1'b0;
        end else if (accept) begin
            done        <= 1'b1;
            take_branch <= take_next;
        end else if (ack) begin
            done        <= 1'b0;
            take_branch <= 1'b0;
        end
    end

    // payload, only loaded on accept
    always_ff @(posedge clock) begin
        if (accept) begin
            tag           <= rob_tag;
            // taken branch writes the link address
            value         <= take_next ? npc : alu_result;
            branch_target <= alu_result;
        end
    end

    // unacknowledged result must not change
    assert property (@(posedge clock) disable iff (reset)
        done && !ack |=> $stable(tag) && $stable(value));

    assert property (@(posedge clock) disable iff (reset)
        !ready |-> done);

endmodule

`default_nettype wire

// ==== hw/branch_cond.sv ====
// conditional branch evaluator for the six rv32i compare conditions
`timescale 1ns/1ps
`default_nettype none

module branch_cond
    import rv_isa_pkg::*;
(
    input  branch_funct3_e  func,
    input  logic [xlen-1:0] rs1,
    input  logic [xlen-1:0] rs2,
    output logic            take
);

    logic signed [xlen-1:0] signed_rs1;
    logic signed [xlen-1:0] signed_rs2;

    assign signed_rs1 = rs1;
    assign signed_rs2 = rs2;

    always_comb begin
        case (func)
            beq:     take = rs1 == rs2;
            bne:     take = rs1 != rs2;
            blt:     take = signed_rs1 <  signed_rs2;
            bge:     take = signed_rs1 >= signed_rs2;
            bltu:    take = rs1 <  rs2;
            bgeu:    take = rs1 >= rs2;
            // funct3 2 and 3 are not branches
            default: take = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cdb_arbiter.sv ====
// round-robin arbiter granting one finished alu unit per cycle onto the common data bus
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter
    import rv_isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [num_alu_fu-1:0]   done,
    input  logic [rob_tag_bits-1:0] tag [num_alu_fu],
    input  logic [xlen-1:0]         value [num_alu_fu],
    input  logic [num_alu_fu-1:0]   take_branch,
    input  logic [xlen-1:0]         branch_target [num_alu_fu],
    output logic [num_alu_fu-1:0]   ack,
    output logic                    cdb_valid,
    output logic [rob_tag_bits-1:0] cdb_tag,
    output logic [xlen-1:0]         cdb_value,
    output logic                    cdb_take_branch,
    output logic [xlen-1:0]         cdb_branch_target
);

    // last granted unit, lowest priority next
    logic [fu_idx_bits-1:0] last_grant;
    logic [fu_idx_bits-1:0] grant_idx;
    logic                   grant_valid;

    // search starts one past the last grant and wraps
    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int k = 1; k <= num_alu_fu; k++) begin
            cand = (int'(last_grant) + k) % num_alu_fu;
            if (!grant_valid && done[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = fu_idx_bits'(cand);
            end
        end
    end

    always_comb begin
        ack = '0;
        if (grant_valid) begin
            ack[grant_idx] = 1'b1;
        end
    end

    // unit 0 first after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            last_grant <= fu_idx_bits'(num_alu_fu - 1);
        end else if (grant_valid) begin
            last_grant <= grant_idx;
        end
    end

    // bus is a copy of the granted unit's register
    assign cdb_valid         = grant_valid;
    assign cdb_tag           = tag[grant_idx];
    assign cdb_value         = value[grant_idx];
    assign cdb_take_branch   = grant_valid & take_branch[grant_idx];
    assign cdb_branch_target = branch_target[grant_idx];

    assert property (@(posedge clock) disable iff (reset)
        $onehot0(ack));

    // never ack an idle unit
    assert property (@(posedge clock) disable iff (reset)
        (ack & ~done) == '0);

endmodule

`default_nettype wire

// ==== hw/exec_cluster.sv ====
// integer execute cluster: generated alu units sharing one cdb through a round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module exec_cluster
    import rv_isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [num_alu_fu-1:0]   issue_valid,
    input  logic [rob_tag_bits-1:0] rob_tag [num_alu_fu],
    input  alu_func_e               alu_func [num_alu_fu],
    input  opa_select_e             opa_select [num_alu_fu],
    input  opb_select_e             opb_select [num_alu_fu],
    input  logic [31:0]             inst [num_alu_fu],
    input  logic [xlen-1:0]         pc [num_alu_fu],
    input  logic [xlen-1:0]         npc [num_alu_fu],
    input  logic [xlen-1:0]         rs1_value [num_alu_fu],
    input  logic [xlen-1:0]         rs2_value [num_alu_fu],
    input  logic [num_alu_fu-1:0]   cond_branch,
    input  logic [num_alu_fu-1:0]   uncond_branch,
    output logic [num_alu_fu-1:0]   ready,
    output logic                    cdb_valid,
    output logic [rob_tag_bits-1:0] cdb_tag,
    output logic [xlen-1:0]         cdb_value,
    output logic                    cdb_take_branch,
    output logic [xlen-1:0]         cdb_branch_target
);

    // unit to arbiter
    logic [num_alu_fu-1:0]   done;
    logic [num_alu_fu-1:0]   ack;
    logic [rob_tag_bits-1:0] tag [num_alu_fu];
    logic [xlen-1:0]         value [num_alu_fu];
    logic [num_alu_fu-1:0]   take_branch;
    logic [xlen-1:0]         branch_target [num_alu_fu];

    for (genvar i = 0; i < num_alu_fu; i++) begin : g_fu
        alu_fu i_alu_fu (
            .clock         (clock),
            .reset         (reset),
            .issue_valid   (issue_valid[i]),
            .rob_tag       (rob_tag[i]),
            .alu_func      (alu_func[i]),
            .opa_select    (opa_select[i]),
            .opb_select    (opb_select[i]),
            .inst          (inst[i]),
            .pc            (pc[i]),
            .npc           (npc[i]),
            .rs1_value     (rs1_value[i]),
            .rs2_value     (rs2_value[i]),
            .cond_branch   (cond_branch[i]),
            .uncond_branch (uncond_branch[i]),
            .ack           (ack[i]),
            .ready         (ready[i]),
            .done          (done[i]),
            .tag           (tag[i]),
            .value         (value[i]),
            .take_branch   (take_branch[i]),
            .branch_target (branch_target[i])
        );
    end

    cdb_arbiter i_cdb_arbiter (
        .clock             (clock),
        .reset             (reset),
        .done              (done),
        .tag               (tag),
        .value             (value),
        .take_branch       (take_branch),
        .branch_target     (branch_target),
        .ack               (ack),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .cdb_value         (cdb_value),
        .cdb_take_branch   (cdb_take_branch),
        .cdb_branch_target (cdb_branch_target)
    );

endmodule

`default_nettype wire

// ==== hw/ooo_pkg.sv ====
// out-of-order machine definitions: rob tag width and alu unit count
`default_nettype none

package ooo_pkg;

    // reorder buffer tag width
    localparam int rob_tag_bits = 5;

    // alu functional units in the execute cluster
    localparam int num_alu_fu = 2;

    // index width for one unit, never below one bit
    localparam int fu_idx_bits = (num_alu_fu > 1) ? $clog2(num_alu_fu) : 1;

endpackage

`default_nettype wire

// ==== hw/operand_select.sv ====
// alu operand multiplexers with rv32i immediate extraction and sign extension
`timescale 1ns/1ps
`default_nettype none

module operand_select
    import rv_isa_pkg::*;
(
    input  opa_select_e     opa_select,
    input  opb_select_e     opb_select,
    input  logic [31:0]     inst,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] npc,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    output logic [xlen-1:0] opa,
    output logic [xlen-1:0] opb
);

    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    // i type, inst[31:20]
    assign i_imm = {{(xlen-12){inst[31]}}, inst[31:20]};
    // s type, split across funct7 and rd fields
    assign s_imm = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    // b type, bit 0 always zero
    assign b_imm = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    // u type, upper 20 bits
    assign u_imm = {inst[31:12], 12'b0};
    // j type, scrambled 20-bit offset
    assign j_imm = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opa_select)
            opa_is_rs1:  opa = rs1_value;
            opa_is_npc:  opa = npc;
            opa_is_pc:   opa = pc;
            opa_is_zero: opa = '0;
            default:     opa = poison_opa;
        endcase
    end

    always_comb begin
        case (opb_select)
            opb_is_rs2:   opb = rs2_value;
            opb_is_i_imm: opb = i_imm;
            opb_is_s_imm: opb = s_imm;
            opb_is_b_imm: opb = b_imm;
            opb_is_u_imm: opb = u_imm;
            opb_is_j_imm: opb = j_imm;
            // codes 6 and 7
            default:      opb = poison_opb;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
// rv32i isa definitions: data width, alu and operand-select encodings, branch conditions
`default_nettype none

package rv_isa_pkg;

    // data path width
    localparam int xlen = 32;

    // alu operation, 4-bit code
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_slt,
        alu_sltu,
        alu_or,
        alu_xor,
        alu_srl,
        alu_sll,
        alu_sra
    } alu_func_e;

    // operand a source
    typedef enum logic [1:0] {
        opa_is_rs1,
        opa_is_npc,
        opa_is_pc,
        opa_is_zero
    } opa_select_e;

    // operand b source, codes 6 and 7 are illegal
    typedef enum logic [2:0] {
        opb_is_rs2,
        opb_is_i_imm,
        opb_is_s_imm,
        opb_is_b_imm,
        opb_is_u_imm,
        opb_is_j_imm
    } opb_select_e;

    // conditional branch funct3 encodings
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    // recognisable words for illegal codes
    localparam logic [xlen-1:0] poison_opa = 32'hdead_face;
    localparam logic [xlen-1:0] poison_opb = 32'hface_feed;
    localparam logic [xlen-1:0] poison_alu = 32'hface_beec;

endpackage

`default_nettype wire

// ==== tb/exec_cluster_tb.sv ====
// testbench for the execute cluster with directed and random issue and a cdb scoreboard
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb
    import rv_isa_pkg::*;
    import ooo_pkg::*;
();

    localparam int num_tags    = 1 << rob_tag_bits;
    localparam int stall_limit = 50;
    localparam int drain_limit = 100;

    // one issued instruction without its tag
    typedef struct packed {
        alu_func_e   func;
        opa_select_e opa_sel;
        opb_select_e opb_sel;
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        cond;
        logic        uncond;
    } instr_t;

    typedef struct packed {
        logic        take;
        logic [31:0] value;
        logic [31:0] target;
    } expect_t;

    logic                    clock;
    logic                    reset;
    logic [num_alu_fu-1:0]   issue_valid;
    logic [rob_tag_bits-1:0] rob_tag [num_alu_fu];
    alu_func_e               alu_func [num_alu_fu];
    opa_select_e             opa_select [num_alu_fu];
    opb_select_e             opb_select [num_alu_fu];
    logic [31:0]             inst [num_alu_fu];
    logic [xlen-1:0]         pc [num_alu_fu];
    logic [xlen-1:0]         npc [num_alu_fu];
    logic [xlen-1:0]         rs1_value [num_alu_fu];
    logic [xlen-1:0]         rs2_value [num_alu_fu];
    logic [num_alu_fu-1:0]   cond_branch;
    logic [num_alu_fu-1:0]   uncond_branch;
    logic [num_alu_fu-1:0]   ready;
    logic                    cdb_valid;
    logic [rob_tag_bits-1:0] cdb_tag;
    logic [xlen-1:0]         cdb_value;
    logic                    cdb_take_branch;
    logic [xlen-1:0]         cdb_branch_target;

    // scoreboard indexed by rob tag
    expect_t                 sb_exp [num_tags];
    bit                      sb_valid [num_tags];
    int                      in_flight;
    int                      accepted_total;
    int                      results_seen;
    int                      dual_accepts;
    // cycles where some unit holds a result and shows ready low
    int                      held_cycles;
    instr_t                  pend [num_alu_fu][$];
    logic [rob_tag_bits-1:0] next_tag;
    logic [31:0]             lfsr_state;

    exec_cluster i_dut (
        .clock             (clock),
        .reset             (reset),
        .issue_valid       (issue_valid),
        .rob_tag           (rob_tag),
        .alu_func          (alu_func),
        .opa_select        (opa_select),
        .opb_select        (opb_select),
        .inst              (inst),
        .pc                (pc),
        .npc               (npc),
        .rs1_value         (rs1_value),
        .rs2_value         (rs2_value),
        .cond_branch       (cond_branch),
        .uncond_branch     (uncond_branch),
        .ready             (ready),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .cdb_value         (cdb_value),
        .cdb_take_branch   (cdb_take_branch),
        .cdb_branch_target (cdb_branch_target)
    );

    // 8 ns period
    initial clock = 1'b0;
    always #4 clock = ~clock;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting: %s", what);
        abort_run();
    endtask

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, field, got, expected);
            abort_run();
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // expected result from the rv32i definitions
    function automatic expect_t ref_result(input alu_func_e f, input opa_select_e a,
                                           input opb_select_e b, input logic [31:0] word,
                                           input logic [31:0] pc_v, input logic [31:0] npc_v,
                                           input logic [31:0] rs1_v, input logic [31:0] rs2_v,
                                           input logic cond, input logic uncond);
        expect_t     res;
        logic [31:0] opa_v;
        logic [31:0] opb_v;
        logic [31:0] alu_v;
        logic        cmp;
        case (a)
            opa_is_rs1: opa_v = rs1_v;
            opa_is_npc: opa_v = npc_v;
            opa_is_pc:  opa_v = pc_v;
            default:    opa_v = 32'h0;
        endcase
        // immediates by signed widening of the gathered fields
        case (b)
            opb_is_rs2:   opb_v = rs2_v;
            opb_is_i_imm: opb_v = 32'($signed(word[31:20]));
            opb_is_s_imm: opb_v = 32'($signed({word[31:25], word[11:7]}));
            opb_is_b_imm: opb_v = 32'($signed({word[31], word[7], word[30:25],
                                               word[11:8], 1'b0}));
            opb_is_u_imm: opb_v = {word[31:12], 12'h000};
            opb_is_j_imm: opb_v = 32'($signed({word[31], word[19:12], word[20],
                                               word[30:21], 1'b0}));
            default:      opb_v = poison_opb;
        endcase
        case (f)
            alu_add:  alu_v = opa_v + opb_v;
            alu_sub:  alu_v = opa_v - opb_v;
            alu_and:  alu_v = opa_v & opb_v;
            alu_slt:  alu_v = ($signed(opa_v) < $signed(opb_v)) ? 32'd1 : 32'd0;
            alu_sltu: alu_v = (opa_v < opb_v) ? 32'd1 : 32'd0;
            alu_or:   alu_v = opa_v | opb_v;
            alu_xor:  alu_v = opa_v ^ opb_v;
            alu_srl:  alu_v = opa_v >> opb_v[4:0];
            alu_sll:  alu_v = opa_v << opb_v[4:0];
            default:  alu_v = $unsigned($signed(opa_v) >>> opb_v[4:0]);
        endcase
        // compare uses the register values and funct3 2 and 3 never take
        case (word[14:12])
            3'b000:  cmp = rs1_v == rs2_v;
            3'b001:  cmp = rs1_v != rs2_v;
            3'b100:  cmp = $signed(rs1_v) < $signed(rs2_v);
            3'b101:  cmp = $signed(rs1_v) >= $signed(rs2_v);
            3'b110:  cmp = rs1_v < rs2_v;
            3'b111:  cmp = rs1_v >= rs2_v;
            default: cmp = 1'b0;
        endcase
        res.take   = uncond | (cond & cmp);
        res.value  = res.take ? npc_v : alu_v;
        res.target = alu_v;
        return res;
    endfunction

    task automatic add_instr(input int u, input alu_func_e f, input opa_select_e a,
                             input opb_select_e b, input logic [31:0] word,
                             input logic [31:0] pc_v, input logic [31:0] rs1_v,
                             input logic [31:0] rs2_v, input logic cond, input logic uncond);
        instr_t it;
        it.func    = f;
        it.opa_sel = a;
        it.opb_sel = b;
        it.word    = word;
        it.pc      = pc_v;
        it.npc     = pc_v + 32'd4;
        it.rs1     = rs1_v;
        it.rs2     = rs2_v;
        it.cond    = cond;
        it.uncond  = uncond;
        pend[u].push_back(it);
    endtask

    task automatic add_random(input int u);
        logic [1:0] kind;
        kind = 2'(take_bits(2));
        add_instr(u, alu_func_e'(4'(take_bits(4) % 10)), opa_select_e'(2'(take_bits(2))),
                  opb_select_e'(3'(take_bits(3) % 6)), take_bits(32),
                  {30'(take_bits(30)), 2'b00}, take_bits(32), take_bits(32),
                  kind == 2'd1, kind == 2'd2);
    endtask

    task automatic drive_unit(input int u, input instr_t it);
        issue_valid[u]   = 1'b1;
        rob_tag[u]       = next_tag;
        next_tag         = next_tag + 1'b1;
        alu_func[u]      = it.func;
        opa_select[u]    = it.opa_sel;
        opb_select[u]    = it.opb_sel;
        inst[u]          = it.word;
        pc[u]            = it.pc;
        npc[u]           = it.npc;
        rs1_value[u]     = it.rs1;
        rs2_value[u]     = it.rs2;
        cond_branch[u]   = it.cond;
        uncond_branch[u] = it.uncond;
    endtask

    // issue both queues and hold each instruction until accepted
    task automatic run_issue(input bit gaps);
        int stall [num_alu_fu];
        bit accepted [num_alu_fu];
        bit busy;
        for (int u = 0; u < num_alu_fu; u++) begin
            stall[u] = 0;
        end
        busy = 1'b1;
        while (busy) begin
            @(posedge clock);
            for (int u = 0; u < num_alu_fu; u++) begin
                accepted[u] = issue_valid[u] & ready[u];
            end
            @(negedge clock);
            busy = 1'b0;
            for (int u = 0; u < num_alu_fu; u++) begin
                if (issue_valid[u] && !accepted[u]) begin
                    stall[u]++;
                    if (stall[u] > stall_limit) begin
                        timeout_fail($sformatf("ready of unit %0d", u));
                    end
                end else begin
                    stall[u]       = 0;
                    issue_valid[u] = 1'b0;
                    // random idle gap on about a quarter of slots
                    if (pend[u].size() > 0 && !(gaps && take_bits(2) == 32'd0)) begin
                        drive_unit(u, pend[u].pop_front());
                    end
                end
                if (issue_valid[u] || pend[u].size() > 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        while (in_flight != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > drain_limit) begin
                timeout_fail("scoreboard to drain");
            end
        end
    endtask

    // compare retired results first and then record new accepts
    always @(posedge clock) begin : monitor
        int accepts;
        if (!reset) begin
            if (cdb_valid) begin
                if (!sb_valid[cdb_tag]) begin
                    $display("cdb returned tag %0d which is not in flight", cdb_tag);
                    abort_run();
                end else begin
                    check_value("cdb_value", cdb_value, sb_exp[cdb_tag].value);
                    check_value("cdb_take_branch", 32'(cdb_take_branch),
                                32'(sb_exp[cdb_tag].take));
                    check_value("cdb_branch_target", cdb_branch_target,
                                sb_exp[cdb_tag].target);
                    sb_valid[cdb_tag] = 1'b0;
                    in_flight--;
                    results_seen++;
                end
            end
            if (ready != '1) begin
                held_cycles++;
            end
            accepts = 0;
            for (int u = 0; u < num_alu_fu; u++) begin
                if (issue_valid[u] && ready[u]) begin
                    if (sb_valid[rob_tag[u]]) begin
                        $display("tag %0d issued while still in flight", rob_tag[u]);
                        abort_run();
                    end else begin
                        sb_exp[rob_tag[u]] = ref_result(alu_func[u], opa_select[u],
                                                        opb_select[u], inst[u], pc[u],
                                                        npc[u], rs1_value[u], rs2_value[u],
                                                        cond_branch[u], uncond_branch[u]);
                        sb_valid[rob_tag[u]] = 1'b1;
                        in_flight++;
                        accepted_total++;
                        accepts++;
                    end
                end
            end
            if (accepts == num_alu_fu) begin
                dual_accepts++;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] word;
        int          held_before;
        int          dual_before;
        reset          = 1'b1;
        issue_valid    = '0;
        cond_branch    = '0;
        uncond_branch  = '0;
        next_tag       = '0;
        lfsr_state     = 32'h4024_d4b9;
        in_flight      = 0;
        accepted_total = 0;
        results_seen   = 0;
        dual_accepts   = 0;
        held_cycles    = 0;
        for (int t = 0; t < num_tags; t++) begin
            sb_valid[t] = 1'b0;
        end
        for (int u = 0; u < num_alu_fu; u++) begin
            rob_tag[u]    = '0;
            alu_func[u]   = alu_add;
            opa_select[u] = opa_is_rs1;
            opb_select[u] = opb_is_rs2;
            inst[u]       = '0;
            pc[u]         = '0;
            npc[u]        = '0;
            rs1_value[u]  = '0;
            rs2_value[u]  = '0;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_value("ready after reset", 32'(ready), 32'({num_alu_fu{1'b1}}));
        check_value("cdb_valid after reset", 32'(cdb_valid), 32'd0);
        check_value("cdb_take_branch after reset", 32'(cdb_take_branch), 32'd0);

        // all ten functions with signed edges and upper shift bits set
        for (int f = 0; f < 10; f++) begin
            add_instr(0, alu_func_e'(4'(f)), opa_is_rs1, opb_is_rs2, 32'h0000_0033,
                      32'h100, 32'h8000_0000, 32'h0000_0001, 1'b0, 1'b0);
            add_instr(1, alu_func_e'(4'(f)), opa_is_rs1, opb_is_rs2, 32'h0000_0033,
                      32'h104, 32'h7fff_ffff, 32'hffff_ffe1, 1'b0, 1'b0);
            add_instr(f % 2, alu_func_e'(4'(f)), opa_is_rs1, opb_is_i_imm, 32'hfff0_0013,
                      32'h108, 32'hf0f0_1234, 32'h0, 1'b0, 1'b0);
        end
        // every operand a and b source
        for (int a = 0; a < 4; a++) begin
            for (int b = 0; b < 6; b++) begin
                add_instr((a + b) % 2, alu_add, opa_select_e'(2'(a)), opb_select_e'(3'(b)),
                          32'hc3a5_9e87, 32'h0000_4a30, 32'h1357_9bdf, 32'h2468_ace0,
                          1'b0, 1'b0);
            end
        end
        run_issue(1'b0);
        drain_results();

        // six compares taken and not taken with signed against unsigned data
        foreach (pend[k]) begin
            pend[k].delete();
        end
        for (int k = 0; k < 8; k++) begin
            word        = 32'hfe5a_0ee3;
            word[14:12] = 3'(k);
            add_instr(k % 2, alu_add, opa_is_pc, opb_is_b_imm, word, 32'h2000,
                      32'h5, 32'h5, 1'b1, 1'b0);
            add_instr((k + 1) % 2, alu_add, opa_is_pc, opb_is_b_imm, word, 32'h2010,
                      32'hffff_ffff, 32'h1, 1'b1, 1'b0);
            add_instr(k % 2, alu_add, opa_is_pc, opb_is_b_imm, word, 32'h2020,
                      32'h1, 32'hffff_ffff, 1'b1, 1'b0);
        end
        // jal and jalr
        add_instr(0, alu_add, opa_is_pc, opb_is_j_imm, 32'h8010_006f, 32'h3000,
                  32'h0, 32'h0, 1'b0, 1'b1);
        add_instr(1, alu_add, opa_is_rs1, opb_is_i_imm, 32'h0040_0067, 32'h3004,
                  32'h0000_5000, 32'h0, 1'b0, 1'b1);
        run_issue(1'b0);
        drain_results();

        // both units finish together and one result waits a cycle
        held_before = held_cycles;
        dual_before = dual_accepts;
        add_instr(0, alu_xor, opa_is_rs1, opb_is_rs2, 32'h0, 32'h400, 32'h55aa_55aa,
                  32'h0ff0_0ff0, 1'b0, 1'b0);
        add_instr(1, alu_sra, opa_is_rs1, opb_is_rs2, 32'h0, 32'h500, 32'h8765_4321,
                  32'h0000_0008, 1'b0, 1'b0);
        run_issue(1'b0);
        drain_results();
        check_value("simultaneous accept seen", 32'(dual_accepts > dual_before), 32'd1);
        check_value("cycles with a held result", 32'(held_cycles - held_before), 32'd1);

        // long random stream with idle gaps
        for (int n = 0; n < 300; n++) begin
            for (int u = 0; u < num_alu_fu; u++) begin
                add_random(u);
            end
        end
        run_issue(1'b1);
        drain_results();

        if (in_flight == 0 && results_seen == accepted_total) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d results retired for %0d accepted", results_seen, accepted_total);
            abort_run();
        end
    end

endmodule

`default_nettype wire
